// File: hw/rv32_pkg.sv
// RV32 core shared types
`default_nettype none

package rv32_pkg;

  typedef logic [31:0] word_t;      // data and address word
  typedef logic [4:0]  reg_addr_t;  // register index, x0..x31

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,  // register-immediate arithmetic
    OP     = 7'b0110011,  // register-register arithmetic
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opcode_t;

  // encoded as {funct7[5], funct3} where the ISA allows it
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_t;

  typedef enum logic [1:0] {
    A_RS1  = 2'd0,  // register operand
    A_PC   = 2'd1,  // auipc
    A_ZERO = 2'd2   // lui passes the immediate through
  } alu_a_sel_t;

  typedef enum logic [1:0] {
    B_RS2   = 2'd0,
    B_IMM_I = 2'd1,
    B_IMM_U = 2'd2,
    B_SHAMT = 2'd3  // shift amount from instr[24:20]
  } alu_b_sel_t;

  typedef enum logic [1:0] {
    W_NPC = 2'd0,  // link value for jumps
    W_ALU = 2'd1
  } w_sel_t;

  localparam word_t RESET_PC    = 32'h0000_0000;
  localparam word_t INSTR_BYTES = 32'd4;

endpackage

`default_nettype wire

// File: hw/fetch_execute_if.sv
// Fetch to execute link
`default_nettype none

interface fetch_execute_if;

  rv32_pkg::word_t pc;        // address of the word now in execute
  rv32_pkg::word_t npc;       // pc + 4, link value
  rv32_pkg::word_t instr;     // raw memory word
  logic            valid;     // word is on the executed path
  logic            redirect;  // jump executing this cycle
  rv32_pkg::word_t target;    // new fetch address

  modport fetch (
    output pc, npc, instr, valid,
    input  redirect, target
  );

  modport execute (
    input  pc, npc, instr, valid,
    output redirect, target
  );

endinterface

`default_nettype wire

// File: hw/fetch_stage.sv
// Instruction fetch stage
`default_nettype none

module fetch_stage (
  input  logic            CLK,
  input  logic            rst_n,
  output rv32_pkg::word_t imem_addr,
  input  rv32_pkg::word_t imem_rdata,
  fetch_execute_if.fetch  fe
);

  rv32_pkg::word_t addr_q;   // address issued to memory this cycle
  rv32_pkg::word_t pc_q;     // address of the word arriving this cycle
  logic            valid_q;  // arriving word is on the right path

  // next address and the arriving-word flag
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      addr_q  <= rv32_pkg::RESET_PC;
      valid_q <= 1'b0;
    end else begin
      if (fe.redirect) begin
        addr_q <= fe.target;                    // jump wins over sequential
      end else begin
        addr_q <= addr_q + rv32_pkg::INSTR_BYTES;
      end
      valid_q <= !fe.redirect;                  // word issued beside a jump is dead
    end
  end

  // tracks the memory latency, one cycle behind addr_q
  always_ff @(posedge CLK) begin
    pc_q <= addr_q;
  end

  assign imem_addr = addr_q;
  assign fe.pc     = pc_q;
  assign fe.npc    = pc_q + rv32_pkg::INSTR_BYTES;
  assign fe.instr  = imem_rdata;                // memory word straight into execute
  assign fe.valid  = valid_q;

  // jump targets from execute must keep fetch on word boundaries
  a_addr_aligned : assert property (
    @(posedge CLK) disable iff (!rst_n)
    imem_addr[1:0] == 2'b00
  ) else $error("fetch address %h not word aligned", imem_addr);

endmodule

`default_nettype wire

// File: hw/control_unit.sv
// RV32I instruction decoder
`default_nettype none

module control_unit (
  input  rv32_pkg::word_t      instr,
  output rv32_pkg::reg_addr_t  rs1,
  output rv32_pkg::reg_addr_t  rs2,
  output rv32_pkg::reg_addr_t  rd,
  output rv32_pkg::word_t      imm_i,
  output rv32_pkg::word_t      imm_u,
  output rv32_pkg::word_t      imm_j,
  output rv32_pkg::alu_op_t    alu_op,
  output rv32_pkg::alu_a_sel_t alu_a_sel,
  output rv32_pkg::alu_b_sel_t alu_b_sel,
  output rv32_pkg::w_sel_t     w_sel,
  output logic                 reg_write,
  output logic                 jump,
  output logic                 jump_reg
);

  rv32_pkg::opcode_t opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;

  assign opcode = rv32_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  // immediates in position, upper bits zero, execute extends them
  assign imm_i = {20'b0, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {11'b0, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_op    = rv32_pkg::ALU_ADD;  // defaults give a no-op
    alu_a_sel = rv32_pkg::A_RS1;
    alu_b_sel = rv32_pkg::B_RS2;
    w_sel     = rv32_pkg::W_ALU;
    reg_write = 1'b0;
    jump      = 1'b0;
    jump_reg  = 1'b0;
    case (opcode)
      rv32_pkg::OP_IMM: begin
        reg_write = 1'b1;
        alu_b_sel = rv32_pkg::B_IMM_I;
        case (funct3)
          3'b000: alu_op = rv32_pkg::ALU_ADD;
          3'b010: alu_op = rv32_pkg::ALU_SLT;
          3'b011: alu_op = rv32_pkg::ALU_SLTU;
          3'b100: alu_op = rv32_pkg::ALU_XOR;
          3'b110: alu_op = rv32_pkg::ALU_OR;
          3'b111: alu_op = rv32_pkg::ALU_AND;
          3'b001: begin
            alu_op    = rv32_pkg::ALU_SLL;
            alu_b_sel = rv32_pkg::B_SHAMT;
            reg_write = (funct7 == 7'b0000000);  // other funct7 is reserved
          end
          default: begin                         // 3'b101, srli / srai
            alu_op    = funct7[5] ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
            alu_b_sel = rv32_pkg::B_SHAMT;
            reg_write = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      rv32_pkg::OP: begin
        reg_write = 1'b1;
        if (funct7 == 7'b0000000) begin
          alu_op = rv32_pkg::alu_op_t'({1'b0, funct3});  // funct3 maps directly
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op = rv32_pkg::ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          alu_op = rv32_pkg::ALU_SRA;
        end else begin
          reg_write = 1'b0;                              // unsupported, no write
        end
      end
      rv32_pkg::LUI: begin
        reg_write = 1'b1;
        alu_a_sel = rv32_pkg::A_ZERO;  // 0 + imm_u
        alu_b_sel = rv32_pkg::B_IMM_U;
      end
      rv32_pkg::AUIPC: begin
        reg_write = 1'b1;
        alu_a_sel = rv32_pkg::A_PC;
        alu_b_sel = rv32_pkg::B_IMM_U;
      end
      rv32_pkg::JAL: begin
        reg_write = 1'b1;
        jump      = 1'b1;
        w_sel     = rv32_pkg::W_NPC;   // rd gets the link value
      end
      rv32_pkg::JALR: begin
        reg_write = (funct3 == 3'b000);
        jump      = (funct3 == 3'b000);
        jump_reg  = 1'b1;
        w_sel     = rv32_pkg::W_NPC;
      end
      default: ;                       // everything else retires as a no-op
    endcase
  end

endmodule

`default_nettype wire

// File: hw/alu.sv
// RV32I integer ALU
`default_nettype none

module alu (
  input  rv32_pkg::word_t   port_a,
  input  rv32_pkg::word_t   port_b,
  input  rv32_pkg::alu_op_t alu_op,
  output rv32_pkg::word_t   port_out
);

  logic [4:0] shamt;  // shifts only look at the low five bits

  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      rv32_pkg::ALU_ADD:  port_out = port_a + port_b;
      rv32_pkg::ALU_SUB:  port_out = port_a - port_b;
      rv32_pkg::ALU_SLL:  port_out = port_a << shamt;
      rv32_pkg::ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      rv32_pkg::ALU_SLTU: port_out = {31'b0, port_a < port_b};
      rv32_pkg::ALU_XOR:  port_out = port_a ^ port_b;
      rv32_pkg::ALU_SRL:  port_out = port_a >> shamt;
      rv32_pkg::ALU_SRA:  port_out = $unsigned($signed(port_a) >>> shamt);  // sign fill
      rv32_pkg::ALU_OR:   port_out = port_a | port_b;
      rv32_pkg::ALU_AND:  port_out = port_a & port_b;
      default:            port_out = '0;  // unused encodings
    endcase
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// Integer register file
`default_nettype none

module reg_file (
  input  logic                CLK,
  input  logic                rst_n,
  input  rv32_pkg::reg_addr_t rs1,
  input  rv32_pkg::reg_addr_t rs2,
  output rv32_pkg::word_t     rs1_data,
  output rv32_pkg::word_t     rs2_data,
  input  logic                wen,
  input  rv32_pkg::reg_addr_t waddr,
  input  rv32_pkg::word_t     w_data
);

  rv32_pkg::word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= w_data;
    end
  end

  // combinational reads, x0 always zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // execute filters rd == 0 before it gets here
  a_no_x0_write : assert property (
    @(posedge CLK) disable iff (!rst_n)
    wen |-> waddr != '0
  ) else $error("write enable raised for x0");

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
// Decode and execute stage
`default_nettype none

module execute_stage (
  input  logic                CLK,
  input  logic                rst_n,
  fetch_execute_if.execute    fe,
  output logic                retire_valid,
  output rv32_pkg::word_t     retire_pc,
  output logic                rf_wen,
  output rv32_pkg::reg_addr_t rf_waddr,
  output rv32_pkg::word_t     rf_wdata
);

  rv32_pkg::reg_addr_t  rs1, rs2, rd;
  rv32_pkg::word_t      imm_i, imm_u, imm_j;
  rv32_pkg::alu_op_t    alu_op;
  rv32_pkg::alu_a_sel_t alu_a_sel;
  rv32_pkg::alu_b_sel_t alu_b_sel;
  rv32_pkg::w_sel_t     w_sel;
  logic                 reg_write, jump, jump_reg;
  rv32_pkg::word_t      rs1_data, rs2_data;
  rv32_pkg::word_t      imm_i_ext, imm_j_ext, shamt_ext;
  rv32_pkg::word_t      port_a, port_b, alu_out;

  control_unit cu_i (
    .instr(fe.instr), .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm_i(imm_i), .imm_u(imm_u), .imm_j(imm_j),
    .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel), .w_sel(w_sel),
    .reg_write(reg_write), .jump(jump), .jump_reg(jump_reg)
  );

  reg_file rf_i (
    .CLK(CLK), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wen(rf_wen), .waddr(rd), .w_data(rf_wdata)
  );

  alu alu_i (.port_a(port_a), .port_b(port_b), .alu_op(alu_op), .port_out(alu_out));

  assign imm_i_ext = {{20{imm_i[11]}}, imm_i[11:0]};  // 12-bit signed
  assign imm_j_ext = {{11{imm_j[20]}}, imm_j[20:0]};  // 21-bit signed, bit 0 zero
  assign shamt_ext = {27'b0, imm_i[4:0]};

  always_comb begin
    case (alu_a_sel)
      rv32_pkg::A_RS1: port_a = rs1_data;
      rv32_pkg::A_PC:  port_a = fe.pc;
      default:         port_a = '0;  // lui
    endcase
    case (alu_b_sel)
      rv32_pkg::B_RS2:   port_b = rs2_data;
      rv32_pkg::B_IMM_I: port_b = imm_i_ext;
      rv32_pkg::B_IMM_U: port_b = imm_u;  // already in the upper 20 bits
      default:           port_b = shamt_ext;
    endcase
  end

  assign rf_wdata = (w_sel == rv32_pkg::W_NPC) ? fe.npc : alu_out;
  assign rf_wen   = fe.valid && reg_write && (rd != '0);  // x0 writes dropped
  assign rf_waddr = rd;

  // jalr clears bit 0 of the sum
  assign fe.target   = jump_reg ? ((rs1_data + imm_i_ext) & ~32'd1) : (fe.pc + imm_j_ext);
  assign fe.redirect = fe.valid && jump;

  assign retire_valid = fe.valid;
  assign retire_pc    = fe.pc;

  // a jump only comes from a live word, and the next word is always squashed
  a_redirect_bubble : assert property (
    @(posedge CLK) disable iff (!rst_n)
    fe.redirect |-> fe.valid ##1 !fe.valid
  ) else $error("redirect without valid, or wrong-path word not squashed");

endmodule

`default_nettype wire

// File: hw/rv32_core2.sv
// Two-stage RV32I core
`default_nettype none

module rv32_core2 (
  input  logic                CLK,
  input  logic                rst_n,
  output rv32_pkg::word_t     imem_addr,
  input  rv32_pkg::word_t     imem_rdata,
  output logic                retire_valid,
  output rv32_pkg::word_t     retire_pc,
  output logic                rf_wen,
  output rv32_pkg::reg_addr_t rf_waddr,
  output rv32_pkg::word_t     rf_wdata
);

  fetch_execute_if fe_if ();  // pc/instr forward, redirect back

  fetch_stage fetch_i (
    .CLK(CLK),
    .rst_n(rst_n),
    .imem_addr(imem_addr),
    .imem_rdata(imem_rdata),
    .fe(fe_if.fetch)
  );

  execute_stage exec_i (
    .CLK(CLK),
    .rst_n(rst_n),
    .fe(fe_if.execute),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .rf_wen(rf_wen),
    .rf_waddr(rf_waddr),
    .rf_wdata(rf_wdata)
  );

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
// Clock and reset source
`default_nettype none

module clock_gen (
  output logic CLK,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 10;  // period 20
  localparam int RESET_CYCLES = 5;

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst_n <= 1'b1;  // released on an edge, DUT sees it one edge later
  end

endmodule

`default_nettype wire

// File: tb/rv32_core2_tb.sv
// Core testbench with ISA model
`default_nettype none

module rv32_core2_tb;

  localparam int NUM_RETIRES  = 2000;
  localparam int RESET_CYCLES = 5;
  localparam int CLK_PERIOD   = 20;
  // worst case every retire is a jump plus its bubble
  localparam int TIMEOUT = (RESET_CYCLES + 2 * NUM_RETIRES + 20) * CLK_PERIOD;

  logic                CLK, rst_n;
  rv32_pkg::word_t     imem_addr, retire_pc, rf_wdata;
  rv32_pkg::word_t     imem_rdata = '0;  // memory output register
  logic                retire_valid, rf_wen;
  rv32_pkg::reg_addr_t rf_waddr;

  rv32_pkg::word_t mem [0:255];         // program, indexed by addr[9:2]
  rv32_pkg::word_t model_regs [0:31];   // architectural state of the model
  rv32_pkg::word_t model_pc;
  integer          seed;
  int              retired;

  clock_gen clk_i (.CLK(CLK), .rst_n(rst_n));

  rv32_core2 dut_i (
    .CLK(CLK), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
  );

  // synchronous memory, word arrives the cycle after the address
  always @(posedge CLK) begin
    imem_rdata <= mem[imem_addr[9:2]];
  end

  function automatic rv32_pkg::reg_addr_t pick_reg(input logic [7:0] r);
    return (r[7:5] == 3'd0) ? 5'd0 : r[4:0];  // x0 about one time in eight
  endfunction

  task automatic make_program;
    logic [31:0]         k, f, g;
    logic [20:0]         joff;
    logic [2:0]          f3;
    rv32_pkg::reg_addr_t rd, rs1, rs2;
    for (int i = 0; i < 256; i++) begin
      k    = $random(seed);                  // instruction kind
      f    = $random(seed);                  // register fields
      g    = $random(seed);                  // immediates and funct bits
      rd   = pick_reg(f[7:0]);
      rs1  = pick_reg(f[15:8]);
      rs2  = pick_reg(f[23:16]);
      f3   = g[14:12];
      joff = {{11{g[7]}}, g[7:0], 2'b00};    // -512..508 bytes, word multiple
      case (k[3:0])
        4'd4, 4'd5: begin                    // slli, srli, srai
          f3 = g[3] ? 3'd1 : 3'd5;
          mem[i[7:0]] = {1'b0, g[4] && f3 == 3'd5, 5'd0, g[24:20], rs1, f3, rd, 7'b0010011};
        end
        4'd6, 4'd7, 4'd8, 4'd9:              // register-register
          mem[i[7:0]] = {1'b0, g[4] && (f3 == 3'd0 || f3 == 3'd5), 5'd0,
                         rs2, rs1, f3, rd, 7'b0110011};
        4'd10: mem[i[7:0]] = {g[31:12], rd, 7'b0110111};  // lui
        4'd11: mem[i[7:0]] = {g[31:12], rd, 7'b0010111};  // auipc
        4'd12: mem[i[7:0]] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
        // jalr from x0 keeps the target aligned, bit 0 random
        4'd13: mem[i[7:0]] = {2'b00, g[7:0], 1'b0, g[8], 5'd0, 3'b000, rd, 7'b1100111};
        4'd15: mem[i[7:0]] = {g[31:7], 7'b1100011};        // branch, runs as a no-op
        default:                                           // addi .. andi
          mem[i[7:0]] = {g[31:20], rs1, (f3 == 3'd1 || f3 == 3'd5) ? 3'd0 : f3,
                         rd, 7'b0010011};
      endcase
    end
  endtask

  // executes the word at model_pc by the RV32I rules
  task automatic model_step(output logic wen, output rv32_pkg::reg_addr_t rd,
                            output rv32_pkg::word_t val);
    rv32_pkg::word_t ins, a, b, imm_i, imm_u, imm_j, nxt;
    logic [4:0]      sh;
    ins   = mem[model_pc[9:2]];
    rd    = ins[11:7];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt   = model_pc + 32'd4;
    wen   = 1'b1;
    val   = '0;
    case (ins[6:0])
      7'b0010011, 7'b0110011: begin
        if (!ins[5]) b = imm_i;              // immediate form
        sh = b[4:0];
        case (ins[14:12])
          3'd0: val = (ins[5] && ins[30]) ? a - b : a + b;  // sub only in register form
          3'd1: val = a << sh;
          3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3: val = (a < b) ? 32'd1 : 32'd0;
          3'd4: val = a ^ b;
          3'd5: begin
            if (ins[30]) val = $signed(a) >>> sh;
            else val = a >> sh;
          end
          3'd6: val = a | b;
          default: val = a & b;
        endcase
      end
      7'b0110111: val = imm_u;
      7'b0010111: val = model_pc + imm_u;
      7'b1101111: begin
        val = model_pc + 32'd4;
        nxt = model_pc + imm_j;
      end
      7'b1100111: begin
        val = model_pc + 32'd4;
        nxt = (a + imm_i) & ~32'd1;          // target taken before rd changes
      end
      default: wen = 1'b0;                   // anything else is a no-op
    endcase
    wen = wen && (rd != 5'd0);
    if (wen) model_regs[rd] = val;
    model_pc = nxt;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  initial begin
    logic                exp_wen;
    rv32_pkg::reg_addr_t exp_rd;
    rv32_pkg::word_t     exp_pc, exp_val;
    seed    = 32'h54f2c883;
    retired = 0;
    make_program();
    for (int r = 0; r < 32; r++) model_regs[r[4:0]] = '0;
    model_pc = rv32_pkg::RESET_PC;
    @(posedge CLK);                          // fetch registers unknown before this
    while (retired < NUM_RETIRES) begin
      @(negedge CLK);                        // mid-cycle, outputs settled
      if (!rst_n) begin
        check_value("reset imem_addr", rv32_pkg::RESET_PC, imem_addr);
        check_value("reset retire_valid", 32'd0, {31'd0, retire_valid});
        check_value("reset rf_wen", 32'd0, {31'd0, rf_wen});
      end else if (retire_valid) begin
        exp_pc = model_pc;
        model_step(exp_wen, exp_rd, exp_val);
        check_value($sformatf("retire %0d pc", retired), exp_pc, retire_pc);
        check_value($sformatf("retire %0d rf_wen", retired),
                    {31'd0, exp_wen}, {31'd0, rf_wen});
        if (exp_wen) begin
          check_value($sformatf("retire %0d rd", retired),
                      {27'd0, exp_rd}, {27'd0, rf_waddr});
          check_value($sformatf("retire %0d wdata", retired), exp_val, rf_wdata);
        end
        retired++;
      end else begin
        check_value("bubble rf_wen", 32'd0, {31'd0, rf_wen});  // squashed word
      end
    end
    $display("Done: no errors");
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("retirement stalled: %0d of %0d instructions retired", retired, NUM_RETIRES);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: rv32_core2.f
hw/rv32_pkg.sv
hw/fetch_execute_if.sv
hw/fetch_stage.sv
hw/control_unit.sv
hw/alu.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/rv32_core2.sv
tb/clock_gen.sv
tb/rv32_core2_tb.sv

// File: Makefile
# Verilator build for the two-stage RV32I core

TOP       ?= rv32_core2_tb
FILELIST  ?= rv32_core2.f
VERILATOR ?= verilator
SEED_ARGS ?= +verilator+seed+1
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
